//--- flist.f
design/pot_cfg_pkg.sv
design/pot_bus_pkg.sv
design/pot_channel.sv
design/pot_scan_bank.sv
design/pot_reg_port.sv
design/pot_scan_top.sv
sim/pot_scan_assertions.sv
sim/pot_scan_checker.sv
sim/pot_scan_tb.sv

//--- Makefile
# Verilator build and run for the pot scanner testbench

VERILATOR ?= verilator
TOP       ?= pot_scan_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/pot_scan_tb.sv
`timescale 1ns/1ps

module pot_scan_tb;

    localparam int NUM_CH         = 4;
    localparam int NUM_POTS       = 2 * NUM_CH;
    localparam int NUM_FIXED      = 5;
    localparam int NUM_TESTS      = NUM_FIXED + 4;
    localparam int MAX_N          = 240;
    localparam int IDLE_HOLD      = 20;                // Cycles watched with potgo off
    localparam int TIMEOUT_CYCLES = 600 * NUM_TESTS;

    logic                    clk;
    logic                    rst;
    pot_bus_pkg::host_req_t  host;
    logic [NUM_POTS-1:0]     pot_in;
    logic                    ack;
    pot_bus_pkg::pot_rdata_u rdata;
    logic [NUM_POTS-1:0]     pot_dump;

    int n_tab [NUM_TESTS][NUM_POTS];
    int n_now [NUM_POTS];
    int rise_cnt [NUM_POTS];
    int cycles;
    int err_count;
    int check_count;

    pot_cfg_pkg::pot_count_t [NUM_POTS-1:0] exp_tab [NUM_TESTS];
    pot_cfg_pkg::pot_count_t [NUM_POTS-1:0] exp_now;

    // Edge cases for both clamps and some mid-range mixes
    int fixed_n [NUM_FIXED][NUM_POTS] = '{
        '{0, 2, 3, 226, 240, 1, 10, 50},
        '{240, 226, 3, 2, 0, 100, 4, 7},
        '{5, 6, 7, 8, 9, 10, 11, 12},
        '{225, 227, 200, 150, 100, 75, 30, 0},
        '{2, 3, 0, 240, 226, 64, 128, 180}
    };

    pot_scan_top #(
        .NUM_CH     (NUM_CH),
        .DUMP_DELAY (pot_cfg_pkg::DEF_DUMP_DELAY),
        .MAX_COUNT  (pot_cfg_pkg::DEF_MAX_COUNT)
    ) i_pot_scan_top (
        .clk      (clk),
        .rst      (rst),
        .host     (host),
        .pot_in   (pot_in),
        .ack      (ack),
        .rdata    (rdata),
        .pot_dump (pot_dump)
    );

    pot_scan_checker #(
        .NUM_POTS (NUM_POTS)
    ) i_pot_scan_checker (
        .clk         (clk),
        .rst         (rst),
        .host        (host),
        .ack         (ack),
        .rdata       (rdata),
        .pot_dump    (pot_dump),
        .exp_counts  (exp_now),
        .err_count   (err_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Comparator trips N cycles after the dump switch opens
    initial begin
        pot_in = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int i = 0; i < NUM_POTS; i++) begin
                if (pot_dump[i] === 1'b1) begin
                    pot_in[i]   = 1'b0;
                    rise_cnt[i] = 0;
                end else begin
                    if (rise_cnt[i] >= n_now[i]) begin
                        pot_in[i] = 1'b1;
                    end
                    rise_cnt[i]++;
                end
            end
        end
    end

    function automatic pot_cfg_pkg::pot_count_t expected_count(input int n);
        int c;
        c = n + 2;  // Two synchronizer stages
        if (c < pot_cfg_pkg::MIN_COUNT) begin
            c = pot_cfg_pkg::MIN_COUNT;
        end
        if (c > pot_cfg_pkg::DEF_MAX_COUNT) begin
            c = pot_cfg_pkg::DEF_MAX_COUNT;
        end
        return pot_cfg_pkg::pot_count_t'(c);
    endfunction

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int p = 0; p < NUM_POTS; p++) begin
                if (t < NUM_FIXED) begin
                    n_tab[t][p] = fixed_n[t][p];
                end else begin
                    n_tab[t][p] = int'($urandom % (MAX_N + 1));
                end
                exp_tab[t][p] = expected_count(n_tab[t][p]);
            end
        end
    endtask

    // One four-phase transfer that starts and ends just after a rising edge
    task automatic bus_access(input logic we, input logic [3:0] addr, input logic [7:0] wdata,
                              output pot_bus_pkg::pot_rdata_u data);
        host.we    = we;
        host.addr  = addr;
        host.wdata = wdata;
        host.req   = 1'b1;
        @(posedge clk);
        #1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        data     = rdata;
        host.req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] wdata);
        pot_bus_pkg::pot_rdata_u unused;
        bus_access(1'b1, addr, wdata, unused);
    endtask

    task automatic read_reg(input logic [3:0] addr, output pot_bus_pkg::pot_rdata_u data);
        bus_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic read_all_pots();
        pot_bus_pkg::pot_rdata_u rd;
        for (int p = 0; p < NUM_POTS; p++) begin
            read_reg(pot_bus_pkg::ADDR_POT0 + 4'(p), rd);
        end
    endtask

    task automatic wait_dump_high();
        while (pot_dump != '1) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        pot_bus_pkg::pot_rdata_u rd;
        int errs_before;
        int total;
        host = '0;
        rst  = 1'b1;
        for (int p = 0; p < NUM_POTS; p++) begin
            n_now[p] = 0;
        end
        exp_now = '0;
        void'($urandom(60));
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errs_before = err_count + i_pot_scan_top.i_pot_scan_assertions.fail_count;
            for (int p = 0; p < NUM_POTS; p++) begin
                n_now[p] = n_tab[t][p];
            end
            exp_now = exp_tab[t];
            write_reg(pot_bus_pkg::ADDR_POTGO, 8'h01);
            read_reg(pot_bus_pkg::ADDR_ALLPOT, rd);  // Mask was just cleared
            while (rd.allpot != 8'hff) begin
                read_reg(pot_bus_pkg::ADDR_ALLPOT, rd);
            end
            read_all_pots();
            read_reg(4'(9 + t % 7), rd);
            write_reg(4'((3 * t) % 11), 8'hff);  // Never the potgo address
            read_all_pots();
            read_reg(pot_bus_pkg::ADDR_ALLPOT, rd);
            write_reg(pot_bus_pkg::ADDR_POTGO, 8'h00);
            wait_dump_high();
            repeat (IDLE_HOLD) @(posedge clk);
            #1;
            read_all_pots();
            $display("Test %0d finished with %0d errors", t,
                     err_count + i_pot_scan_top.i_pot_scan_assertions.fail_count
                     - errs_before);
        end

        total = err_count + i_pot_scan_top.i_pot_scan_assertions.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, check_count, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- sim/pot_scan_checker.sv
`timescale 1ns/1ps

module pot_scan_checker #(
    parameter int NUM_POTS = 8
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  pot_bus_pkg::host_req_t                 host,
    input  logic                                   ack,
    input  pot_bus_pkg::pot_rdata_u                rdata,
    input  logic [NUM_POTS-1:0]                    pot_dump,
    input  pot_cfg_pkg::pot_count_t [NUM_POTS-1:0] exp_counts,
    output int                                     err_count,
    output int                                     check_count
);

    pot_bus_pkg::host_req_t req_q;
    logic                   ack_q;
    logic                   potgo_on;
    logic [NUM_POTS-1:0]    dump_q;
    logic [NUM_POTS-1:0]    finished;  // Pots done since the last scan start

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0d ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_read(input logic [3:0] addr, input pot_bus_pkg::pot_rdata_u rd);
        int idx;
        idx = int'(addr - pot_bus_pkg::ADDR_POT0);
        if (addr == pot_bus_pkg::ADDR_ALLPOT) begin
            compare("rdata.allpot", rd.allpot, 8'(finished));
        end else if (idx < NUM_POTS) begin
            compare($sformatf("rdata.value (pot %0d)", idx), rd.value, exp_counts[idx]);
        end else begin
            compare($sformatf("rdata (address %0d)", addr), rd.allpot, 8'h00);
        end
    endtask

    // Bus and DUT outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            req_q       = '0;
            ack_q       = 1'b0;
            potgo_on    = 1'b0;
            dump_q      = '1;
            finished    = '0;
            err_count   = 0;
            check_count = 0;
        end else begin
            // Old potgo since a channel may still start in the write cycle
            if (!potgo_on && ((dump_q & ~pot_dump) != '0)) begin
                err_count++;
                $display("A pot left dump at %0d ns while potgo was off", $time);
            end
            if (ack && !ack_q) begin
                if (req_q.we) begin
                    if (req_q.addr == pot_bus_pkg::ADDR_POTGO) begin
                        potgo_on = req_q.wdata[0];
                        if (req_q.wdata[0]) begin
                            finished = '0;
                        end
                    end
                end else begin
                    check_read(req_q.addr, rdata);
                end
            end
            finished = finished | (pot_dump & ~dump_q);  // Finish shows as dump rising
            if (host.req && !ack) begin
                req_q = host;
            end
            dump_q = pot_dump;
            ack_q  = ack;
        end
    end

endmodule

//--- sim/pot_scan_assertions.sv
`timescale 1ns/1ps

module pot_scan_assertions #(
    parameter int NUM_POTS = 8
) (
    input logic                clk,
    input logic                rst,
    input logic                req,
    input logic                ack,
    input logic [NUM_POTS-1:0] pot_dump
);

    int fail_count = 0;

    // Ack only answers a pending request
    ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without req high");
            fail_count++;
        end

    ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    for (genvar i = 0; i < NUM_POTS; i++) begin : g_dump
        // Dump never rises within MIN_COUNT cycles of falling
        dump_low: assert property (@(posedge clk) disable iff (rst)
            $fell(pot_dump[i]) |-> !pot_dump[i] [*pot_cfg_pkg::MIN_COUNT])
            else begin
                $error("pot_dump[%0d] rose before the minimum scan length", i);
                fail_count++;
            end
    end

endmodule

bind pot_scan_top pot_scan_assertions #(
    .NUM_POTS (2 * NUM_CH)
) i_pot_scan_assertions (
    .clk      (clk),
    .rst      (rst),
    .req      (host.req),
    .ack      (ack),
    .pot_dump (pot_dump)
);

//--- design/pot_scan_top.sv
`timescale 1ns/1ps

module pot_scan_top #(
    parameter int NUM_CH     = 4,
    parameter int DUMP_DELAY = pot_cfg_pkg::DEF_DUMP_DELAY,
    parameter int MAX_COUNT  = pot_cfg_pkg::DEF_MAX_COUNT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  pot_bus_pkg::host_req_t  host,
    input  logic [2*NUM_CH-1:0]     pot_in,
    output logic                    ack,
    output pot_bus_pkg::pot_rdata_u rdata,
    output logic [2*NUM_CH-1:0]     pot_dump
);

    logic                                 potgo;
    logic [NUM_CH-1:0]                    lo_done;
    logic [NUM_CH-1:0]                    hi_done;
    pot_cfg_pkg::pot_count_t [NUM_CH-1:0] lo_values;
    pot_cfg_pkg::pot_count_t [NUM_CH-1:0] hi_values;

    pot_scan_bank #(
        .NUM_CH     (NUM_CH),
        .DUMP_DELAY (DUMP_DELAY),
        .MAX_COUNT  (MAX_COUNT)
    ) bank_lo (
        .clk        (clk),
        .rst        (rst),
        .potgo      (potgo),
        .pot_in     (pot_in[NUM_CH-1:0]),
        .pot_dump   (pot_dump[NUM_CH-1:0]),
        .done       (lo_done),
        .pot_values (lo_values)
    );

    pot_scan_bank #(
        .NUM_CH     (NUM_CH),
        .DUMP_DELAY (DUMP_DELAY),
        .MAX_COUNT  (MAX_COUNT)
    ) bank_hi (
        .clk        (clk),
        .rst        (rst),
        .potgo      (potgo),
        .pot_in     (pot_in[2*NUM_CH-1:NUM_CH]),
        .pot_dump   (pot_dump[2*NUM_CH-1:NUM_CH]),
        .done       (hi_done),
        .pot_values (hi_values)
    );

    pot_reg_port #(
        .NUM_CH (NUM_CH)
    ) i_pot_reg_port (
        .clk       (clk),
        .rst       (rst),
        .host      (host),
        .lo_values (lo_values),
        .hi_values (hi_values),
        .lo_done   (lo_done),
        .hi_done   (hi_done),
        .ack       (ack),
        .rdata     (rdata),
        .potgo     (potgo)
    );

endmodule

//--- design/pot_reg_port.sv
`timescale 1ns/1ps

module pot_reg_port #(
    parameter int NUM_CH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  pot_bus_pkg::host_req_t               host,
    input  pot_cfg_pkg::pot_count_t [NUM_CH-1:0] lo_values,
    input  pot_cfg_pkg::pot_count_t [NUM_CH-1:0] hi_values,
    input  logic [NUM_CH-1:0]                    lo_done,
    input  logic [NUM_CH-1:0]                    hi_done,
    output logic                                 ack,
    output pot_bus_pkg::pot_rdata_u              rdata,
    output logic                                 potgo
);

    // NUM_CH is a power of two, so the low address bits pick the channel
    localparam int SEL_W = $clog2(NUM_CH);

    logic [2*NUM_CH-1:0]     allpot_mask;
    logic                    access;
    logic                    potgo_wr;
    logic [3:0]              pot_off;
    logic [SEL_W-1:0]        ch_sel;
    pot_bus_pkg::pot_rdata_u rd_next;

    // New access only once the previous ack has dropped
    assign access   = host.req && !ack;
    assign potgo_wr = access && host.we && (host.addr == pot_bus_pkg::ADDR_POTGO);

    assign pot_off = host.addr - pot_bus_pkg::ADDR_POT0;
    assign ch_sel  = pot_off[SEL_W-1:0];

    // Read mux
    always_comb begin
        rd_next = '0;
        if (host.addr == pot_bus_pkg::ADDR_ALLPOT) begin
            rd_next.allpot[2*NUM_CH-1:0] = allpot_mask;
        end else if (pot_off < 4'(NUM_CH)) begin
            rd_next.value = lo_values[ch_sel];
        end else if (pot_off < 4'(2 * NUM_CH)) begin
            rd_next.value = hi_values[ch_sel];
        end
    end

    // Four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (access) begin
            ack <= 1'b1;
        end else if (!host.req) begin
            ack <= 1'b0;  // Req seen low
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata <= rd_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            potgo <= 1'b0;
        end else if (potgo_wr) begin
            potgo <= host.wdata[0];
        end
    end

    // Sticky completion bits cleared by starting a new scan
    always_ff @(posedge clk) begin
        if (rst) begin
            allpot_mask <= '0;
        end else if (potgo_wr && host.wdata[0]) begin
            allpot_mask <= '0;
        end else begin
            allpot_mask <= allpot_mask | {hi_done, lo_done};
        end
    end

endmodule

//--- design/pot_scan_bank.sv
`timescale 1ns/1ps

module pot_scan_bank #(
    parameter int NUM_CH     = 4,
    parameter int DUMP_DELAY = pot_cfg_pkg::DEF_DUMP_DELAY,
    parameter int MAX_COUNT  = pot_cfg_pkg::DEF_MAX_COUNT
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 potgo,
    input  logic [NUM_CH-1:0]                    pot_in,
    output logic [NUM_CH-1:0]                    pot_dump,
    output logic [NUM_CH-1:0]                    done,
    output pot_cfg_pkg::pot_count_t [NUM_CH-1:0] pot_values
);

    // Paddle comparator outputs are asynchronous to clk
    logic [NUM_CH-1:0] sync_meta;
    logic [NUM_CH-1:0] sync_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta <= '0;
            sync_out  <= '0;
        end else begin
            sync_meta <= pot_in;
            sync_out  <= sync_meta;
        end
    end

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        pot_channel #(
            .DUMP_DELAY (DUMP_DELAY),
            .MAX_COUNT  (MAX_COUNT)
        ) i_pot_channel (
            .clk      (clk),
            .rst      (rst),
            .potgo    (potgo),
            .pot_sync (sync_out[ch]),
            .pot_dump (pot_dump[ch]),
            .done     (done[ch]),
            .value    (pot_values[ch])
        );
    end

endmodule

//--- design/pot_channel.sv
`timescale 1ns/1ps

module pot_channel #(
    parameter int DUMP_DELAY = pot_cfg_pkg::DEF_DUMP_DELAY,
    parameter int MAX_COUNT  = pot_cfg_pkg::DEF_MAX_COUNT
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    potgo,
    input  logic                    pot_sync,
    output logic                    pot_dump,
    output logic                    done,
    output pot_cfg_pkg::pot_count_t value
);

    localparam pot_cfg_pkg::pot_count_t DUMP_LIMIT = pot_cfg_pkg::pot_count_t'(DUMP_DELAY);
    localparam pot_cfg_pkg::pot_count_t MIN_LIMIT  =
        pot_cfg_pkg::pot_count_t'(pot_cfg_pkg::MIN_COUNT - 1);
    localparam pot_cfg_pkg::pot_count_t MAX_LIMIT  = pot_cfg_pkg::pot_count_t'(MAX_COUNT - 1);

    pot_cfg_pkg::pot_state_t state;
    pot_cfg_pkg::pot_state_t state_next;
    pot_cfg_pkg::pot_count_t timer;
    pot_cfg_pkg::pot_count_t timer_next;
    logic                    finish;

    always_comb begin
        state_next = state;
        timer_next = timer;
        finish     = 1'b0;
        case (state)
            pot_cfg_pkg::st_idle: begin
                if (!potgo) begin
                    timer_next = '0;  // Hold in dump
                end else if (timer > DUMP_LIMIT) begin
                    state_next = pot_cfg_pkg::st_scan;
                    timer_next = '0;
                end else begin
                    timer_next = timer + 1'b1;
                end
            end
            pot_cfg_pkg::st_scan: begin
                // Threshold crossed or ceiling hit but never before the minimum
                if ((timer > MIN_LIMIT) && (pot_sync || (timer > MAX_LIMIT))) begin
                    finish     = 1'b1;
                    state_next = pot_cfg_pkg::st_idle;
                    timer_next = '0;
                end else begin
                    timer_next = timer + 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pot_cfg_pkg::st_idle;
            timer <= '0;
            value <= '0;
        end else begin
            state <= state_next;
            timer <= timer_next;
            if (finish) begin
                value <= timer;  // Count at the crossing
            end
        end
    end

    assign pot_dump = (state == pot_cfg_pkg::st_idle);
    assign done     = finish;

endmodule

//--- design/pot_bus_pkg.sv
package pot_bus_pkg;

    // Host request held stable while req is high
    typedef struct packed {
        logic       req;
        logic       we;
        logic [3:0] addr;
        logic [7:0] wdata;
    } host_req_t;

    // Read data is either one pot count or the completion mask
    typedef union packed {
        pot_cfg_pkg::pot_count_t value;
        logic [7:0]              allpot;  // One bit per pot with the low bank in 3:0
    } pot_rdata_u;

    // Register map
    localparam logic [3:0] ADDR_POT0   = 4'd0;   // Pot n at ADDR_POT0 + n
    localparam logic [3:0] ADDR_ALLPOT = 4'd8;
    localparam logic [3:0] ADDR_POTGO  = 4'd11;

endpackage

//--- design/pot_cfg_pkg.sv
package pot_cfg_pkg;

    // Count width matches the 8-bit POT registers
    typedef logic [7:0] pot_count_t;

    // Idle covers both dump and waiting for potgo
    typedef enum logic {
        st_idle = 1'b0,
        st_scan = 1'b1
    } pot_state_t;

    // Defaults for the scan timing
    localparam int DEF_DUMP_DELAY = 8;    // Dump cycles minus two before scan
    localparam int DEF_MAX_COUNT  = 228;  // Count ceiling

    // A scan cannot finish before this count even with the input already high
    localparam int MIN_COUNT = 5;

endpackage
